// ==== hw/conv_pkg.sv ====
package conv_pkg;

    // -------------------------------------------------------------------
    // bus and datapath widths
    // -------------------------------------------------------------------
    localparam int BUS_W          = 32;   // global buffer word
    localparam int ACT_W          = 8;    // weight / ifmap element
    localparam int PSUM_W         = 16;   // partial sum
    localparam int LANES          = BUS_W / ACT_W;   // elements per word
    localparam int PSUMS_PER_WORD = BUS_W / PSUM_W;  // psums per word

    typedef logic signed [ACT_W-1:0]  act_t;
    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic        [BUS_W-1:0]  word_t;

    // -------------------------------------------------------------------
    // controller phases
    // -------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,
        IFMAP_LOAD,
        IPSUM_LOAD,
        COMPUTE,
        WRITEBACK,    // results into psum buffer
        OPSUM_OUT
    } ctrl_state_t;

endpackage

// ==== hw/conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [$clog2(ROWS+1)-1:0]                    row_en,
    input  logic                                         valid_w,
    input  logic                                         valid_if,
    input  logic                                         valid_ip,
    input  logic                                         ready_op,
    output logic                                         ready_w,
    output logic                                         ready_if,
    output logic                                         ready_ip,
    output logic                                         valid_op,
    output logic                                         w_we,
    output logic                                         if_we,
    output logic                                         ip_we,
    output logic [$clog2(ROWS*COLS/conv_pkg::LANES)-1:0] word_idx,
    output logic                                         mac_first,
    output logic                                         mac_en,
    output logic                                         wb_en
);
    import conv_pkg::*;

    localparam int WPR   = COLS / LANES;            // words per weight row
    localparam int IDX_W = $clog2(ROWS * COLS / LANES);
    localparam int CW    = IDX_W + 1;

    ctrl_state_t      state, next_state;
    logic [IDX_W-1:0] cnt;
    logic [CW-1:0]    w_words;
    logic             w_xfer, if_xfer, ip_xfer, op_xfer;
    logic             w_last, if_last, pair_last, step_last;
    logic             phase_done;

    // -------------------------------------------------------------------
    // phase lengths from row_en
    // -------------------------------------------------------------------
    assign w_words   = CW'(row_en * WPR);
    assign w_last    = ({1'b0, cnt} == w_words - CW'(1));
    assign if_last   = (cnt == IDX_W'(WPR - 1));
    assign pair_last = (cnt == IDX_W'(row_en >> 1) - IDX_W'(1));   // ipsum and opsum
    assign step_last = (cnt == IDX_W'(WPR - 1));

    assign w_xfer  = valid_w  && ready_w;
    assign if_xfer = valid_if && ready_if;
    assign ip_xfer = valid_ip && ready_ip;
    assign op_xfer = valid_op && ready_op;

    assign phase_done = (w_xfer && w_last) || (if_xfer && if_last) ||
                        (ip_xfer && pair_last) || (op_xfer && pair_last) ||
                        (mac_en && step_last);

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE:        if (valid_w) next_state = WEIGHT_LOAD;
                         else if (valid_if) next_state = IFMAP_LOAD;
            WEIGHT_LOAD: if (w_xfer && w_last) next_state = IFMAP_LOAD;
            IFMAP_LOAD:  if (if_xfer && if_last) next_state = IPSUM_LOAD;
            IPSUM_LOAD:  if (ip_xfer && pair_last) next_state = COMPUTE;
            COMPUTE:     if (step_last) next_state = WRITEBACK;
            WRITEBACK:   next_state = OPSUM_OUT;
            OPSUM_OUT:   if (op_xfer && pair_last) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= next_state;
            if (phase_done)
                cnt <= '0;                          // each phase counts from zero
            else if (w_xfer || if_xfer || ip_xfer || op_xfer || mac_en)
                cnt <= cnt + IDX_W'(1);
        end
    end

    // handshake and buffer controls
    assign ready_w   = (state == WEIGHT_LOAD);
    assign ready_if  = (state == IFMAP_LOAD);
    assign ready_ip  = (state == IPSUM_LOAD);
    assign valid_op  = (state == OPSUM_OUT);
    assign w_we      = w_xfer;
    assign if_we     = if_xfer;
    assign ip_we     = ip_xfer;
    assign mac_en    = (state == COMPUTE);
    assign mac_first = mac_en && (cnt == '0);   // seed from ipsum
    assign wb_en     = (state == WRITEBACK);
    assign word_idx  = cnt;                     // also the compute step

    // -------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------
    // every transfer and step lands inside its phase's word range
    a_xfer_in_phase: assert property (@(posedge clk) disable iff (reset)
        (!w_xfer || ({1'b0, cnt} < w_words)) &&
        (!(if_xfer || mac_en) || (cnt < IDX_W'(WPR))) &&
        (!(ip_xfer || op_xfer) || (cnt < IDX_W'(row_en >> 1))));

    a_row_en_ok: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE && (valid_w || valid_if)) |->
            (!row_en[0] && row_en >= 2 && row_en <= ROWS));

    a_op_hold: assert property (@(posedge clk) disable iff (reset)
        (valid_op && !ready_op) |=> (valid_op && $stable(cnt)));

endmodule

// ==== hw/weight_buffer.sv ====
`timescale 1ns/1ps

module weight_buffer #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                         clk,
    input  logic                                         w_we,
    input  logic [$clog2(ROWS*COLS/conv_pkg::LANES)-1:0] word_idx,
    input  conv_pkg::word_t                              data_in,
    output conv_pkg::word_t                              step_weights [ROWS]
);
    import conv_pkg::*;

    localparam int WPR   = COLS / LANES;
    localparam int DEPTH = ROWS * WPR;

    word_t mem [DEPTH];   // row-major, WPR words per row

    // loaded in stream order, kept across passes
    always_ff @(posedge clk) begin
        if (w_we)
            mem[word_idx] <= data_in;
    end

    // one word per row for the current step
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            step_weights[r] = mem[r * WPR + int'(word_idx)];
        end
    end

    a_w_depth: assert property (@(posedge clk)
        w_we |-> (int'(word_idx) < DEPTH));

endmodule

// ==== hw/ifmap_buffer.sv ====
`timescale 1ns/1ps

module ifmap_buffer #(
    parameter int COLS = 8
) (
    input  logic                                    clk,
    input  logic                                    if_we,
    input  logic [((COLS/conv_pkg::LANES > 1) ?
                   $clog2(COLS/conv_pkg::LANES) : 1)-1:0] word_idx,
    input  conv_pkg::word_t                         data_in,
    output conv_pkg::word_t                         step_ifmap
);
    import conv_pkg::*;

    localparam int WPR = COLS / LANES;   // words per ifmap vector

    word_t mem [WPR];

    always_ff @(posedge clk) begin
        if (if_we)
            mem[word_idx] <= data_in;   // lowest channel in low byte
    end

    // same word feeds every row
    assign step_ifmap = mem[word_idx];

endmodule

// ==== hw/psum_buffer.sv ====
`timescale 1ns/1ps

module psum_buffer #(
    parameter int ROWS = 8
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               ip_we,
    input  logic                                               wb_en,
    input  logic [((ROWS/2 > 1) ? $clog2(ROWS/2) : 1)-1:0]     word_idx,
    input  logic [$clog2(ROWS+1)-1:0]                          row_en,
    input  conv_pkg::word_t                                    data_in,
    input  conv_pkg::psum_t                                    results [ROWS],
    output conv_pkg::psum_t                                    psums [ROWS],
    output conv_pkg::word_t                                    data_out
);
    import conv_pkg::*;

    // -------------------------------------------------------------------
    // ipsum in, results written back in place
    // -------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < ROWS; r++)
                psums[r] <= '0;
        end else if (ip_we) begin
            for (int p = 0; p < PSUMS_PER_WORD; p++)   // even row in low half
                psums[PSUMS_PER_WORD * int'(word_idx) + p] <=
                    psum_t'(data_in[p*PSUM_W +: PSUM_W]);
        end else if (wb_en) begin
            for (int r = 0; r < ROWS; r++) begin
                if (r < int'(row_en))
                    psums[r] <= results[r];   // inactive rows keep old value
            end
        end
    end

    // opsum word for the current index
    always_comb begin
        for (int p = 0; p < PSUMS_PER_WORD; p++)
            data_out[p*PSUM_W +: PSUM_W] = psums[PSUMS_PER_WORD * int'(word_idx) + p];
    end

endmodule

// ==== hw/pe_array.sv ====
`timescale 1ns/1ps

module pe_array #(
    parameter int ROWS = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            mac_first,
    input  logic            mac_en,
    input  conv_pkg::word_t step_weights [ROWS],
    input  conv_pkg::word_t step_ifmap,
    input  conv_pkg::psum_t psums [ROWS],
    output conv_pkg::psum_t results [ROWS]
);
    import conv_pkg::*;

    psum_t step_sum [ROWS];   // four-lane dot product per row

    function automatic psum_t lane_product(input act_t w, input act_t x);
        return psum_t'(w) * psum_t'(x);   // sign extended first
    endfunction

    // -------------------------------------------------------------------
    // per-row multipliers and adder tree
    // -------------------------------------------------------------------
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            step_sum[r] = '0;
            for (int l = 0; l < LANES; l++) begin
                step_sum[r] = step_sum[r] +
                    lane_product(step_weights[r][l*ACT_W +: ACT_W],
                                 step_ifmap[l*ACT_W +: ACT_W]);
            end
        end
    end

    // -------------------------------------------------------------------
    // accumulators, 16 bit wrap
    // -------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < ROWS; r++)
                results[r] <= '0;
        end else if (mac_first) begin
            for (int r = 0; r < ROWS; r++)
                results[r] <= psums[r] + step_sum[r];     // seed with ipsum
        end else if (mac_en) begin
            for (int r = 0; r < ROWS; r++)
                results[r] <= results[r] + step_sum[r];
        end
    end

endmodule

// ==== hw/conv_unit.sv ====
`timescale 1ns/1ps

module conv_unit #(
    parameter int ROWS = 8,   // even
    parameter int COLS = 8    // multiple of LANES
) (
    input  logic                      clk,
    input  logic                      reset,
    input  conv_pkg::word_t           data_in,
    input  logic [$clog2(ROWS+1)-1:0] row_en,
    input  logic                      valid_w,
    input  logic                      valid_if,
    input  logic                      valid_ip,
    input  logic                      ready_op,
    output conv_pkg::word_t           data_out,
    output logic                      ready_w,
    output logic                      ready_if,
    output logic                      ready_ip,
    output logic                      valid_op
);
    import conv_pkg::*;

    localparam int IDX_W    = $clog2(ROWS * COLS / LANES);
    localparam int IF_IDX_W = (COLS / LANES > 1) ? $clog2(COLS / LANES) : 1;
    localparam int PS_IDX_W = (ROWS / 2 > 1) ? $clog2(ROWS / 2) : 1;

    logic             w_we, if_we, ip_we;
    logic             mac_first, mac_en, wb_en;
    logic [IDX_W-1:0] word_idx;
    word_t            step_weights [ROWS];
    word_t            step_ifmap;
    psum_t            psums [ROWS];
    psum_t            results [ROWS];

    // -------------------------------------------------------------------
    // control
    // -------------------------------------------------------------------
    conv_ctrl #(.ROWS(ROWS), .COLS(COLS)) ctrl0 (
        .clk(clk), .reset(reset), .row_en(row_en),
        .valid_w(valid_w), .valid_if(valid_if), .valid_ip(valid_ip),
        .ready_op(ready_op), .ready_w(ready_w), .ready_if(ready_if),
        .ready_ip(ready_ip), .valid_op(valid_op),
        .w_we(w_we), .if_we(if_we), .ip_we(ip_we), .word_idx(word_idx),
        .mac_first(mac_first), .mac_en(mac_en), .wb_en(wb_en)
    );

    // -------------------------------------------------------------------
    // buffers and datapath
    // -------------------------------------------------------------------
    weight_buffer #(.ROWS(ROWS), .COLS(COLS)) wbuf0 (
        .clk(clk), .w_we(w_we), .word_idx(word_idx),
        .data_in(data_in), .step_weights(step_weights)
    );

    ifmap_buffer #(.COLS(COLS)) ibuf0 (
        .clk(clk), .if_we(if_we), .word_idx(word_idx[IF_IDX_W-1:0]),
        .data_in(data_in), .step_ifmap(step_ifmap)
    );

    psum_buffer #(.ROWS(ROWS)) pbuf0 (
        .clk(clk), .reset(reset), .ip_we(ip_we), .wb_en(wb_en),
        .word_idx(word_idx[PS_IDX_W-1:0]), .row_en(row_en),
        .data_in(data_in), .results(results),
        .psums(psums), .data_out(data_out)
    );

    pe_array #(.ROWS(ROWS)) pe0 (
        .clk(clk), .reset(reset), .mac_first(mac_first), .mac_en(mac_en),
        .step_weights(step_weights), .step_ifmap(step_ifmap),
        .psums(psums), .results(results)
    );

endmodule

// ==== verification/tb_conv_unit.sv ====
`timescale 1ns/1ps

module tb_conv_unit;
    import conv_pkg::*;

    localparam int ROWS    = 8;
    localparam int COLS    = 8;
    localparam int WPR     = COLS / LANES;      // words per weight row
    localparam int RE_W    = $clog2(ROWS + 1);
    localparam int TIMEOUT = 200;               // cycles allowed per wait

    logic            clk, reset;
    word_t           data_in, data_out;
    logic [RE_W-1:0] row_en;
    logic            valid_w, valid_if, valid_ip, ready_op;
    logic            ready_w, ready_if, ready_ip, valid_op;

    word_t w_model [ROWS*WPR];   // weights the DUT should hold
    word_t if_model [WPR];
    word_t ip_model [ROWS/2];
    word_t tx_words [ROWS*WPR];
    word_t exp_q [$];            // expected opsum words in order
    int    seed = 50;
    int    rx_count, errors, checks, tests;

    conv_unit #(.ROWS(ROWS), .COLS(COLS)) dut0 (
        .clk(clk), .reset(reset), .data_in(data_in), .row_en(row_en),
        .valid_w(valid_w), .valid_if(valid_if), .valid_ip(valid_ip),
        .ready_op(ready_op), .data_out(data_out), .ready_w(ready_w),
        .ready_if(ready_if), .ready_ip(ready_ip), .valid_op(valid_op)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // reference model and checking
    // ------------------------------------------------------------------
    function automatic word_t expected_word(input int i);
        word_t packed_word;
        int    r, acc;
        act_t  wt, x;
        packed_word = '0;
        for (int h = 0; h < PSUMS_PER_WORD; h++) begin
            r   = PSUMS_PER_WORD * i + h;                       // low half is the even row
            acc = int'(psum_t'(ip_model[i][h*PSUM_W +: PSUM_W]));
            for (int c = 0; c < COLS; c++) begin
                wt  = w_model[r*WPR + c/LANES][(c%LANES)*ACT_W +: ACT_W];
                x   = if_model[c/LANES][(c%LANES)*ACT_W +: ACT_W];
                acc = acc + int'(wt) * int'(x);
            end
            packed_word[h*PSUM_W +: PSUM_W] = acc[15:0];        // 16 bit wrap
        end
        return packed_word;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // every opsum transfer against the queue
    always @(posedge clk) begin
        if (!reset && valid_op && ready_op) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected extra opsum word %h at %0t ns", data_out, $time);
            end else begin
                check_value("opsum word", data_out, exp_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    function automatic word_t act_word(input bit extreme);
        word_t w;
        w = $random(seed);
        if (extreme) begin
            for (int l = 0; l < LANES; l++)
                w[l*ACT_W +: ACT_W] = w[l*ACT_W] ? 8'h7f : 8'h80;
        end
        return w;
    endfunction

    function automatic word_t psum_word(input bit extreme);
        word_t w;
        w = $random(seed);
        if (extreme) begin
            for (int p = 0; p < PSUMS_PER_WORD; p++)
                w[p*PSUM_W +: PSUM_W] = w[p*PSUM_W] ? 16'h7ffe : 16'h8001;
        end
        return w;
    endfunction

    function automatic logic stream_ready(input int kind);
        case (kind)
            0:       return ready_w;
            1:       return ready_if;
            default: return ready_ip;
        endcase
    endfunction

    task automatic drive_valid(input int kind, input logic v);
        case (kind)
            0:       valid_w = v;
            1:       valid_if = v;
            default: valid_ip = v;
        endcase
    endtask

    task automatic send_words(input int kind, input int n, input string what);
        int waited;
        for (int k = 0; k < n; k++) begin
            data_in = tx_words[k];
            drive_valid(kind, 1'b1);
            waited = 0;
            while (!stream_ready(kind) && waited < TIMEOUT) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (!stream_ready(kind)) begin
                errors++;
                $display("timeout: DUT never accepted %s word %0d", what, k);
                break;
            end
            @(posedge clk);   // transfer edge
            #2;
        end
        drive_valid(kind, 1'b0);
    endtask

    task automatic collect_opsums(input int n, input bit throttle);
        int waited;
        waited = 0;
        while (rx_count < n && waited < TIMEOUT) begin
            if (throttle)
                ready_op = 1'($random(seed));   // random back-pressure
            @(posedge clk);
            #2;
            waited++;
        end
        ready_op = 1'b1;
        if (rx_count < n) begin
            errors++;
            $display("timeout: only %0d of %0d opsum words arrived", rx_count, n);
        end
    endtask

    task automatic run_pass(input int rows, input bit load_w, input bit throttle,
                            input bit extreme);
        row_en   = RE_W'(rows);
        rx_count = 0;
        if (load_w) begin
            for (int k = 0; k < rows * WPR; k++) begin
                tx_words[k] = act_word(extreme);
                w_model[k]  = tx_words[k];
            end
            send_words(0, rows * WPR, "weight");
        end
        for (int j = 0; j < WPR; j++) begin
            tx_words[j] = act_word(extreme);
            if_model[j] = tx_words[j];
        end
        send_words(1, WPR, "ifmap");
        for (int i = 0; i < rows / 2; i++) begin
            tx_words[i] = psum_word(extreme);
            ip_model[i] = tx_words[i];
            exp_q.push_back(expected_word(i));
        end
        send_words(2, rows / 2, "ipsum");
        collect_opsums(rows / 2, throttle);
        check_value("opsum word count", 32'(rx_count), 32'(rows / 2));
        check_value("valid_op after last word", 32'(valid_op), 32'd0);
        exp_q.delete();
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        int mark;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        rx_count = 0;
        reset    = 1'b1;
        data_in  = '0;
        row_en   = RE_W'(ROWS);
        valid_w  = 1'b0;
        valid_if = 1'b0;
        valid_ip = 1'b0;
        ready_op = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        mark = errors;
        check_value("handshake outputs after reset",
                    32'({ready_w, ready_if, ready_ip, valid_op}), 32'd0);
        end_test(1, "outputs low after reset", mark);

        mark = errors;
        run_pass(ROWS, 1'b1, 1'b0, 1'b0);
        end_test(2, "full pass", mark);

        mark = errors;
        run_pass(ROWS, 1'b0, 1'b0, 1'b0);   // weights kept
        end_test(3, "weight reuse", mark);

        mark = errors;
        run_pass(2, 1'b1, 1'b0, 1'b0);      // new weights for rows 0 and 1 only
        run_pass(ROWS, 1'b0, 1'b0, 1'b0);
        end_test(4, "two active rows", mark);

        mark = errors;
        run_pass(ROWS, 1'b0, 1'b1, 1'b0);
        end_test(5, "opsum back-pressure", mark);

        mark = errors;
        run_pass(ROWS, 1'b1, 1'b0, 1'b1);
        end_test(6, "extreme operands", mark);

        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/conv_pkg.sv
hw/conv_ctrl.sv
hw/weight_buffer.sv
hw/ifmap_buffer.sv
hw/psum_buffer.sv
hw/pe_array.sv
hw/conv_unit.sv
verification/tb_conv_unit.sv

// ==== Makefile ====
SIM       = verilator
TOP       = tb_conv_unit
RTL_TOP   = conv_unit
FILELIST  = build.f
FLAGS     = --binary --timing --assert -Wno-fatal
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
